/* src/storeBufPkg.sv */
`default_nettype none

package storeBufPkg;

  // Word address, store data and byte mask
  localparam int addrW = 30;
  localparam int dataW = 32;
  localparam int selW  = 4;

  // One buffered store as kept in the FIFO
  localparam int entryW = addrW + dataW + selW;

  // Entry layout with the mask at the bottom and the address on top
  localparam int selLo  = 0;
  localparam int dataLo = selLo + selW;
  localparam int addrLo = dataLo + dataW;

  // Number of buffered stores
  localparam int sbDepth = 4;

  // Drain engine states
  typedef enum logic [0:0] {
    drainIdle,
    drainBus
  } drainState;

endpackage

`default_nettype wire

/* src/openFifo4FloppedPtr.sv */
`timescale 1ns/10ps
`default_nettype none

module openFifo4FloppedPtr #(
  parameter int DWIDTH = 32,
  localparam int AWIDTH = 2
) (
  input  wire                              clk,
  input  wire                              rstN,
  input  wire [DWIDTH-1:0]                 fifoInData,
  input  wire                              push,
  input  wire                              pop,
  output logic [DWIDTH-1:0]                fifoOutData,
  output logic                             fifoFull,
  output logic                             fifoEmpty,
  output logic [DWIDTH-1:0]                d0,
  output logic [DWIDTH-1:0]                d1,
  output logic [DWIDTH-1:0]                d2,
  output logic [DWIDTH-1:0]                d3,
  output logic [storeBufPkg::sbDepth-1:0]  dValid,
  output logic [AWIDTH-1:0]                dPtr
);

  import storeBufPkg::*;

  logic [AWIDTH-1:0] wrPtr;
  logic [AWIDTH-1:0] rdPtr;
  logic [AWIDTH-1:0] nxtWrPtr;
  logic [AWIDTH-1:0] nxtRdPtr;
  logic              nxtEmpty;
  logic              nxtFull;
  logic [sbDepth-1:0] wrEn;
  logic [sbDepth-1:0] nxtValid;
  logic [DWIDTH-1:0] mem [sbDepth];

  assign nxtWrPtr = push ? wrPtr + AWIDTH'(1) : wrPtr;
  assign nxtRdPtr = pop ? rdPtr + AWIDTH'(1) : rdPtr;

  // Pointers move only on push or pop
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push)
        wrPtr <= nxtWrPtr;
      if (pop)
        rdPtr <= nxtRdPtr;
    end
  end

  // Head pointer as it will be next cycle
  assign dPtr = nxtRdPtr;

  // Equal pointers mean empty or full, decided by the last move
  always_comb begin
    if (nxtWrPtr != nxtRdPtr)
      nxtEmpty = 1'b0;
    else if (pop && !push)
      nxtEmpty = 1'b1;
    else
      nxtEmpty = fifoEmpty;
  end

  always_comb begin
    if (nxtWrPtr != nxtRdPtr)
      nxtFull = 1'b0;
    else if (push && !pop)
      nxtFull = 1'b1;
    else
      nxtFull = fifoFull;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fifoEmpty <= 1'b1;
      fifoFull  <= 1'b0;
    end else begin
      fifoEmpty <= nxtEmpty;
      fifoFull  <= nxtFull;
    end
  end

  // Per-entry write enables
  always_comb begin
    for (int i = 0; i < sbDepth; i++) begin
      wrEn[i] = push && (wrPtr == AWIDTH'(i));
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < sbDepth; i++) begin
      if (wrEn[i])
        mem[i] <= fifoInData;
    end
  end

  assign d0 = mem[0];
  assign d1 = mem[1];
  assign d2 = mem[2];
  assign d3 = mem[3];

  assign fifoOutData = mem[rdPtr];

  // Valid bits follow push and pop, a push into the popped slot keeps it valid
  always_comb begin
    nxtValid = dValid;
    if (pop)
      nxtValid[rdPtr] = 1'b0;
    if (push)
      nxtValid[wrPtr] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rstN)
      dValid <= '0;
    else
      dValid <= nxtValid;
  end

endmodule

`default_nettype wire

/* src/storeForward.sv */
`timescale 1ns/10ps
`default_nettype none

module storeForward #(
  parameter int DWIDTH = 66
) (
  input  wire                              clk,
  input  wire                              rstN,
  input  wire                              loadValid,
  input  wire [storeBufPkg::addrW-1:0]     loadAddr,
  input  wire [DWIDTH-1:0]                 d0,
  input  wire [DWIDTH-1:0]                 d1,
  input  wire [DWIDTH-1:0]                 d2,
  input  wire [DWIDTH-1:0]                 d3,
  input  wire [storeBufPkg::sbDepth-1:0]   dValid,
  input  wire [1:0]                        dPtr,
  output logic                             fwdValid,
  output logic                             fwdHit,
  output logic                             fwdConflict,
  output logic [storeBufPkg::dataW-1:0]    fwdData
);

  import storeBufPkg::*;

  logic [1:0]        headPtr;
  logic [DWIDTH-1:0] entry [sbDepth];
  logic              matchFound;
  logic [DWIDTH-1:0] matchEntry;
  logic              fullMask;

  // Registered copy of the head, equal to the current read pointer
  always_ff @(posedge clk) begin
    if (!rstN)
      headPtr <= '0;
    else
      headPtr <= dPtr;
  end

  assign entry[0] = d0;
  assign entry[1] = d1;
  assign entry[2] = d2;
  assign entry[3] = d3;

  // Walk from oldest to youngest, so the last match wins
  always_comb begin : search
    logic [1:0] slot;
    matchFound = 1'b0;
    matchEntry = '0;
    for (int k = 0; k < sbDepth; k++) begin
      slot = headPtr + 2'(k);
      if (dValid[slot] && (entry[slot][addrLo +: addrW] == loadAddr)) begin
        matchFound = 1'b1;
        matchEntry = entry[slot];
      end
    end
  end

  // Partial masks cannot be merged here
  assign fullMask = &matchEntry[selLo +: selW];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fwdValid    <= 1'b0;
      fwdHit      <= 1'b0;
      fwdConflict <= 1'b0;
    end else begin
      fwdValid    <= loadValid;
      fwdHit      <= loadValid && matchFound && fullMask;
      fwdConflict <= loadValid && matchFound && !fullMask;
    end
  end

  always_ff @(posedge clk) begin
    fwdData <= matchEntry[dataLo +: dataW];
  end

endmodule

`default_nettype wire

/* src/wbDrain.sv */
`timescale 1ns/10ps
`default_nettype none

module wbDrain (
  input  wire                              clk,
  input  wire                              rstN,
  input  wire [storeBufPkg::entryW-1:0]    fifoOutData,
  input  wire                              fifoEmpty,
  output logic                             pop,
  output logic                             wbCyc,
  output logic                             wbStb,
  output logic                             wbWe,
  output logic [storeBufPkg::addrW-1:0]    wbAdr,
  output logic [storeBufPkg::dataW-1:0]    wbDatO,
  output logic [storeBufPkg::selW-1:0]     wbSel,
  input  wire                              wbAck
);

  import storeBufPkg::*;

  drainState state;
  logic      startXfer;

  // Start only from idle, which leaves a gap cycle after each ack
  assign startXfer = (state == drainIdle) && !fifoEmpty;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= drainIdle;
    end else begin
      case (state)
        drainIdle: begin
          if (startXfer)
            state <= drainBus;
        end
        drainBus: begin
          if (wbAck)
            state <= drainIdle;
        end
        default: state <= drainIdle;
      endcase
    end
  end

  // Head entry held on the bus for the whole transfer
  always_ff @(posedge clk) begin
    if (startXfer) begin
      wbAdr  <= fifoOutData[addrLo +: addrW];
      wbDatO <= fifoOutData[dataLo +: dataW];
      wbSel  <= fifoOutData[selLo +: selW];
    end
  end

  assign wbCyc = (state == drainBus);
  assign wbStb = (state == drainBus);
  assign wbWe  = (state == drainBus);

  // One pop per acknowledged write
  assign pop = (state == drainBus) && wbAck;

endmodule

`default_nettype wire

/* src/storeBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module storeBuffer (
  input  wire                              clk,
  input  wire                              rstN,
  input  wire                              storeValid,
  input  wire [storeBufPkg::addrW-1:0]     storeAddr,
  input  wire [storeBufPkg::dataW-1:0]     storeData,
  input  wire [storeBufPkg::selW-1:0]      storeSel,
  output logic                             storeReady,
  input  wire                              loadValid,
  input  wire [storeBufPkg::addrW-1:0]     loadAddr,
  output logic                             fwdValid,
  output logic                             fwdHit,
  output logic                             fwdConflict,
  output logic [storeBufPkg::dataW-1:0]    fwdData,
  output logic                             idle,
  output logic                             wbCyc,
  output logic                             wbStb,
  output logic                             wbWe,
  output logic [storeBufPkg::addrW-1:0]    wbAdr,
  output logic [storeBufPkg::dataW-1:0]    wbDatO,
  output logic [storeBufPkg::selW-1:0]     wbSel,
  input  wire                              wbAck
);

  import storeBufPkg::*;

  localparam int DWIDTH = entryW;

  logic [DWIDTH-1:0]  fifoInData;
  logic [DWIDTH-1:0]  fifoOutData;
  logic               push;
  logic               pop;
  logic               fifoFull;
  logic               fifoEmpty;
  logic [DWIDTH-1:0]  d0;
  logic [DWIDTH-1:0]  d1;
  logic [DWIDTH-1:0]  d2;
  logic [DWIDTH-1:0]  d3;
  logic [sbDepth-1:0] dValid;
  logic [1:0]         dPtr;

  // Packed as address, data, mask from top to bottom
  assign fifoInData = {storeAddr, storeData, storeSel};
  assign storeReady = !fifoFull;
  assign push       = storeValid && !fifoFull;
  assign idle       = fifoEmpty;

  openFifo4FloppedPtr #(.DWIDTH(DWIDTH)) fifo0 (
    .clk(clk), .rstN(rstN), .fifoInData(fifoInData), .push(push), .pop(pop),
    .fifoOutData(fifoOutData), .fifoFull(fifoFull), .fifoEmpty(fifoEmpty),
    .d0(d0), .d1(d1), .d2(d2), .d3(d3), .dValid(dValid), .dPtr(dPtr)
  );

  storeForward #(.DWIDTH(DWIDTH)) fwd0 (
    .clk(clk), .rstN(rstN), .loadValid(loadValid), .loadAddr(loadAddr),
    .d0(d0), .d1(d1), .d2(d2), .d3(d3), .dValid(dValid), .dPtr(dPtr),
    .fwdValid(fwdValid), .fwdHit(fwdHit), .fwdConflict(fwdConflict), .fwdData(fwdData)
  );

  wbDrain drain0 (
    .clk(clk), .rstN(rstN), .fifoOutData(fifoOutData), .fifoEmpty(fifoEmpty), .pop(pop),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
    .wbSel(wbSel), .wbAck(wbAck)
  );

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Released at the tenth rising edge, so ten edges see reset low
  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/wbMemModel.sv */
`timescale 1ns/10ps
`default_nettype none

module wbMemModel (
  input  wire         clk,
  input  wire         rstN,
  input  wire         stall,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire  [29:0] wbAdr,
  input  wire  [31:0] wbDatO,
  input  wire  [3:0]  wbSel,
  output logic        wbAck
);

  logic [31:0] mem [64];
  logic [31:0] lcgState;
  logic [1:0]  waitCnt;
  logic        busy;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    for (int i = 0; i < 64; i++)
      mem[i] = 32'hc0de0000 ^ (32'(i) * 32'h01030507);
  end

  // Each request waits 0 to 3 cycles, and stall holds the ack back
  always @(posedge clk) begin
    if (!rstN) begin
      wbAck    <= 1'b0;
      busy     <= 1'b0;
      waitCnt  <= '0;
      lcgState <= 32'heb0c;
    end else begin
      wbAck <= 1'b0;
      if (wbCyc && wbStb && !wbAck) begin
        if (!busy) begin
          busy     <= 1'b1;
          waitCnt  <= lcgState[17:16];
          lcgState <= lcgNext(lcgState);
        end else if (waitCnt != 2'd0) begin
          waitCnt <= waitCnt - 2'd1;
        end else if (!stall) begin
          wbAck <= 1'b1;
          busy  <= 1'b0;
          for (int b = 0; b < 4; b++) begin
            if (wbWe && wbSel[b])
              mem[wbAdr[5:0]][8*b +: 8] <= wbDatO[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/storeBuffer_props.sv */
`timescale 1ns/10ps
`default_nettype none

module fifoProps (
  input wire clk,
  input wire rstN,
  input wire push,
  input wire pop,
  input wire fifoFull,
  input wire fifoEmpty
);

  noOverflow: assert property (@(posedge clk) disable iff (!rstN)
    !(push && fifoFull && !pop))
    else $error("push into a full FIFO without a pop");

  noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
    !(pop && fifoEmpty))
    else $error("pop from an empty FIFO");

  flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(fifoFull && fifoEmpty))
    else $error("FIFO flags full and empty both high");

endmodule

bind openFifo4FloppedPtr fifoProps props0 (
  .clk(clk), .rstN(rstN), .push(push), .pop(pop), .fifoFull(fifoFull), .fifoEmpty(fifoEmpty)
);

`default_nettype wire

/* testbench/storeBufferTb.sv */
`timescale 1ns/10ps
`default_nettype none

module storeBufferTb;

  localparam int timeoutCycles = 400;

  logic        clk;
  logic        rstN;
  logic        storeValid;
  logic [29:0] storeAddr;
  logic [31:0] storeData;
  logic [3:0]  storeSel;
  logic        storeReady;
  logic        loadValid;
  logic [29:0] loadAddr;
  logic        fwdValid;
  logic        fwdHit;
  logic        fwdConflict;
  logic [31:0] fwdData;
  logic        idle;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [29:0] wbAdr;
  logic [31:0] wbDatO;
  logic [3:0]  wbSel;
  logic        wbAck;
  logic        stall;

  // Buffered stores oldest first as {addr, data, sel}, and a mirror of memory
  logic [65:0] refQ[$];
  logic [31:0] refMem [64];
  logic [33:0] expFwd;
  logic [31:0] lcgState;
  int errCount;
  int testCount;
  int failCount;
  int hitCount;
  int conflictCount;
  int loadsIssued;
  int loadsChecked;
  int pushCount;
  int writeCount;

  tbClock clk0 (.clk(clk), .rstN(rstN));

  storeBuffer dut0 (
    .clk(clk), .rstN(rstN), .storeValid(storeValid), .storeAddr(storeAddr),
    .storeData(storeData), .storeSel(storeSel), .storeReady(storeReady),
    .loadValid(loadValid), .loadAddr(loadAddr), .fwdValid(fwdValid), .fwdHit(fwdHit),
    .fwdConflict(fwdConflict), .fwdData(fwdData), .idle(idle), .wbCyc(wbCyc),
    .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO), .wbSel(wbSel), .wbAck(wbAck)
  );

  wbMemModel mem0 (
    .clk(clk), .rstN(rstN), .stall(stall), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
    .wbAdr(wbAdr), .wbDatO(wbDatO), .wbSel(wbSel), .wbAck(wbAck)
  );

  function automatic logic [31:0] lcgRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // The youngest store to the word decides between hit and conflict
  function automatic logic [33:0] expectFwd(input logic [29:0] addr);
    for (int i = refQ.size() - 1; i >= 0; i--) begin
      if (refQ[i][65:36] == addr)
        return {refQ[i][3:0] == 4'hf, refQ[i][3:0] != 4'hf, refQ[i][35:4]};
    end
    return '0;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    errCount++;
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic pushStore(input logic [29:0] addr, input logic [31:0] data,
                           input logic [3:0] sel, output logic readyAtStart);
    int n;
    storeValid = 1'b1;
    storeAddr = addr;
    storeData = data;
    storeSel = sel;
    readyAtStart = storeReady;
    n = 0;
    while (!storeReady && n < timeoutCycles) begin
      nextCycle();
      n++;
    end
    if (!storeReady) begin
      $display("Timed out at %0t waiting for the buffer to accept a store", $time);
      errCount++;
    end
    nextCycle();
    storeValid = 1'b0;
  endtask

  task automatic issueLoad(input logic [29:0] addr);
    loadValid = 1'b1;
    loadAddr = addr;
    nextCycle();
    loadValid = 1'b0;
  endtask

  // Buffer empty and every load answered
  task automatic settle();
    int n;
    n = 0;
    while (!(idle && loadsChecked == loadsIssued) && n < timeoutCycles) begin
      nextCycle();
      n++;
    end
    if (!(idle && loadsChecked == loadsIssued)) begin
      $display("Timed out at %0t waiting for the buffer to drain", $time);
      errCount++;
    end
  endtask

  task automatic checkMemory();
    for (int i = 0; i < 64; i++) begin
      assert (mem0.mem[i] === refMem[i])
        else reportMismatch($sformatf("mem[%0d]", i), mem0.mem[i], refMem[i]);
    end
    assert (writeCount == pushCount)
      else reportMismatch("bus write count", 32'(writeCount), 32'(pushCount));
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    testCount++;
    if (errCount != errsBefore)
      failCount++;
    $display("Test %0d %s: %s", testCount, name, (errCount == errsBefore) ? "ok" : "FAILED");
  endtask

  // A load in cycle n is answered in cycle n+1
  always @(negedge clk) begin
    if (rstN) begin
      if (fwdValid) begin
        loadsChecked++;
        if (fwdHit)
          hitCount++;
        if (fwdConflict)
          conflictCount++;
        assert (fwdHit === expFwd[33]) else reportMismatch("fwdHit", 32'(fwdHit), 32'(expFwd[33]));
        assert (fwdConflict === expFwd[32])
          else reportMismatch("fwdConflict", 32'(fwdConflict), 32'(expFwd[32]));
        if (expFwd[33])
          assert (fwdData === expFwd[31:0]) else reportMismatch("fwdData", fwdData, expFwd[31:0]);
      end
      if (loadValid) begin
        loadsIssued++;
        expFwd = expectFwd(loadAddr);
      end
      // Strobe and write enable go with the cycle
      if (wbCyc) begin
        assert (wbStb === 1'b1) else reportMismatch("wbStb", 32'(wbStb), 32'd1);
        assert (wbWe === 1'b1) else reportMismatch("wbWe", 32'(wbWe), 32'd1);
      end
      if (wbCyc && wbStb && wbAck) begin
        writeCount++;
        if (refQ.size() == 0) begin
          $display("Bus write at %0t with no store left in the buffer", $time);
          errCount++;
        end else begin
          assert (wbAdr === refQ[0][65:36])
            else reportMismatch("wbAdr", 32'(wbAdr), 32'(refQ[0][65:36]));
          assert (wbDatO === refQ[0][35:4]) else reportMismatch("wbDatO", wbDatO, refQ[0][35:4]);
          assert (wbSel === refQ[0][3:0])
            else reportMismatch("wbSel", 32'(wbSel), 32'(refQ[0][3:0]));
          for (int b = 0; b < 4; b++) begin
            if (refQ[0][b])
              refMem[refQ[0][41:36]][8*b +: 8] = refQ[0][4 + 8*b +: 8];
          end
          void'(refQ.pop_front());
        end
      end
      if (storeValid && storeReady) begin
        pushCount++;
        refQ.push_back({storeAddr, storeData, storeSel});
      end
    end
  end

  initial begin
    int errsBefore;
    int hitsBefore;
    int conflictsBefore;
    int n;
    logic ready;
    logic [31:0] w;
    storeValid = 1'b0;
    storeAddr = '0;
    storeData = '0;
    storeSel = '0;
    loadValid = 1'b0;
    loadAddr = '0;
    stall = 1'b0;
    expFwd = '0;
    lcgState = 32'heb0c;
    n = 0;
    while (!rstN && n < timeoutCycles) begin
      nextCycle();
      n++;
    end
    if (!rstN) begin
      $display("Timed out waiting for reset release");
      errCount++;
    end
    for (int i = 0; i < 64; i++)
      refMem[i] = mem0.mem[i];

    errsBefore = errCount;
    assert (wbCyc === 1'b0) else reportMismatch("wbCyc", 32'(wbCyc), 32'd0);
    assert (fwdValid === 1'b0) else reportMismatch("fwdValid", 32'(fwdValid), 32'd0);
    assert (idle === 1'b1) else reportMismatch("idle", 32'(idle), 32'd1);
    assert (storeReady === 1'b1) else reportMismatch("storeReady", 32'(storeReady), 32'd1);
    finishTest("reset state", errsBefore);

    errsBefore = errCount;
    for (int i = 0; i < 24; i++) begin
      w = lcgRand();
      pushStore(30'(w[5:2]), lcgRand(), w[8] ? 4'hf : (4'h1 << w[10:9]), ready);
      issueLoad(30'(w[17:14]));
    end
    settle();
    checkMemory();
    finishTest("ordered drain", errsBefore);

    errsBefore = errCount;
    stall = 1'b1;
    for (int i = 0; i < 4; i++) begin
      pushStore(30'(20 + i), lcgRand(), 4'hf, ready);
      assert (ready === 1'b1) else reportMismatch("storeReady", 32'(ready), 32'd1);
    end
    // A fifth store waits while memory holds off
    storeValid = 1'b1;
    storeAddr = 30'd24;
    storeData = 32'h0badcafe;
    storeSel = 4'hf;
    for (int i = 0; i < 8; i++) begin
      assert (storeReady === 1'b0) else reportMismatch("storeReady", 32'(storeReady), 32'd0);
      nextCycle();
    end
    stall = 1'b0;
    pushStore(30'd24, 32'h0badcafe, 4'hf, ready);
    pushStore(30'd20, lcgRand(), 4'h3, ready);
    settle();
    checkMemory();
    finishTest("back-pressure", errsBefore);

    errsBefore = errCount;
    hitsBefore = hitCount;
    stall = 1'b1;
    pushStore(30'd40, 32'h11110001, 4'hf, ready);
    issueLoad(30'd40);
    pushStore(30'd41, 32'h22220002, 4'hf, ready);
    pushStore(30'd40, 32'h33330003, 4'hf, ready);
    issueLoad(30'd40);
    issueLoad(30'd41);
    issueLoad(30'd42);
    stall = 1'b0;
    settle();
    assert (hitCount - hitsBefore == 3)
      else reportMismatch("hit count", 32'(hitCount - hitsBefore), 32'd3);
    finishTest("forwarding", errsBefore);

    errsBefore = errCount;
    conflictsBefore = conflictCount;
    stall = 1'b1;
    pushStore(30'd50, 32'h44440004, 4'hf, ready);
    pushStore(30'd50, 32'h55550005, 4'h3, ready);
    pushStore(30'd51, 32'h66660006, 4'hc, ready);
    issueLoad(30'd50);
    issueLoad(30'd51);
    stall = 1'b0;
    settle();
    assert (conflictCount - conflictsBefore == 2)
      else reportMismatch("conflict count", 32'(conflictCount - conflictsBefore), 32'd2);
    hitsBefore = hitCount;
    conflictsBefore = conflictCount;
    issueLoad(30'd50);
    issueLoad(30'd51);
    settle();
    assert (hitCount == hitsBefore && conflictCount == conflictsBefore)
      else reportMismatch("drained load matches", 32'(hitCount + conflictCount),
                          32'(hitsBefore + conflictsBefore));
    checkMemory();
    finishTest("conflict and miss", errsBefore);

    $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failCount, errCount);
    if (errCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/storeBufPkg.sv
src/openFifo4FloppedPtr.sv
src/storeForward.sv
src/wbDrain.sv
src/storeBuffer.sv
testbench/tbClock.sv
testbench/wbMemModel.sv
testbench/storeBuffer_props.sv
testbench/storeBufferTb.sv

/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module storeBuffer -f filelist.f

sim:
	verilator --binary --timing --assert --top-module storeBufferTb -f filelist.f -o storeBufferTb
	./obj_dir/storeBufferTb | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
